//--- mem_bus_cfg.svh
`ifndef MEM_BUS_CFG_SVH
`define MEM_BUS_CFG_SVH

// bus widths
`define MB_ADDR_W 32
`define MB_DATA_W 32

// memory map
// internal RAM covers [0, MB_INT_MEM_WORDS)
`define MB_INT_MEM_WORDS 256
// external SRAM covers [MB_INT_MEM_WORDS, MB_EXT_MEM_END)
`define MB_EXT_MEM_END 65536
`define MB_SRAM_ADDR_W 16

// rs232 transmit port, single word near the top of the map
`define MB_RS232_DATA_ADDR 32'hffff_fff0

// clock and line rate, their ratio gives the bit period in clocks
`define MB_CLK_FREQ 10_000_000
`define MB_BAUD 1_000_000

`endif

//--- mem_bus_pkg.sv
`default_nettype none

`include "mem_bus_cfg.svh"

package mem_bus_pkg;

  typedef logic [`MB_ADDR_W-1:0]      addr_t;       // bus address
  typedef logic [`MB_DATA_W-1:0]      data_t;       // bus data word
  typedef logic [`MB_SRAM_ADDR_W-1:0] sram_addr_t;  // address on the SRAM pins
  typedef logic [7:0]                 ram_index_t;  // word index into the startup RAM

  // external SRAM controller states
  typedef enum logic [2:0] {
    st_wait        = 3'd0,
    st_rd_set_addr = 3'd1,
    st_rd_data_get = 3'd2,
    st_rd_finish   = 3'd3,
    st_wr_set_addr = 3'd4,
    st_wr_set_we   = 3'd5,
    st_wr_finish   = 3'd6
  } sram_state_t;

endpackage

`default_nettype wire

//--- mem_bus_if.sv
`timescale 1ns/1ps
`default_nettype none

// request side of the bus, one master and several slaves
// responses travel on separate ports and get ORed at the top
interface mem_bus_if
  import mem_bus_pkg::*;
();

  addr_t addr;     // held stable for the whole request
  data_t wdata;    // write payload
  logic  read_q;   // level request
  logic  write_q;  // level request, never together with read_q
  logic  rw_halt;  // blocks new accesses, aborts SRAM ones

  modport master (
    output addr, wdata, read_q, write_q, rw_halt
  );

  modport slave (
    input addr, wdata, read_q, write_q, rw_halt
  );

endinterface

`default_nettype wire

//--- int_startup_ram.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_bus_cfg.svh"

module int_startup_ram
  import mem_bus_pkg::*;
(
  input  logic     clk,
  input  logic     reset,
  mem_bus_if.slave bus,
  output data_t    rdata,
  output logic     read_dn,
  output logic     write_dn
);

  data_t      mem [`MB_INT_MEM_WORDS];  // startup image
  data_t      rd_word;                  // word shown during read_dn
  ram_index_t idx;
  logic       hit;
  logic       guard;

  // blank startup contents
  initial begin
    for (int i = 0; i < `MB_INT_MEM_WORDS; i++) begin
      mem[i] = '0;
    end
  end

  assign idx = bus.addr[$bits(ram_index_t)-1:0];  // low bits only, range checked below

  // still answering, master drops its request next cycle
  assign guard = read_dn || write_dn;

  assign hit = (bus.addr < addr_t'(`MB_INT_MEM_WORDS)) && !bus.rw_halt && !guard;

  always_ff @(posedge clk) begin
    if (reset) begin
      read_dn  <= 1'b0;
      write_dn <= 1'b0;
    end else begin
      read_dn  <= hit && bus.read_q;   // one cycle latency
      write_dn <= hit && bus.write_q;
    end
  end

  always_ff @(posedge clk) begin
    if (hit && bus.write_q) begin
      mem[idx] <= bus.wdata;
    end
    if (hit && bus.read_q) begin
      rd_word <= mem[idx];
    end
  end

  assign rdata = read_dn ? rd_word : '0;  // zero when idle, the top ORs slaves

endmodule

`default_nettype wire

//--- ext_sram_ctlr.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_bus_cfg.svh"

module ext_sram_ctlr
  import mem_bus_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  mem_bus_if.slave   bus,
  output data_t      rdata,
  output logic       read_dn,
  output logic       write_dn,
  output sram_addr_t prg_addr,
  output data_t      prg_wdata,
  input  data_t      prg_rdata,
  output logic       prg_wdata_en,  // data pins driven by us
  output logic       prg_ce_n,
  output logic       prg_oe_n,
  output logic       prg_we_n
);

  sram_state_t state;
  sram_state_t state_nxt;
  addr_t       addr_q;      // request address, frozen once we leave st_wait
  addr_t       ext_offset;  // address relative to start of SRAM
  data_t       wdata_q;
  data_t       rd_word;     // sampled SRAM data
  logic        hit;

  // SRAM window sits right above the internal RAM
  assign hit = (bus.addr >= addr_t'(`MB_INT_MEM_WORDS)) &&
               (bus.addr < addr_t'(`MB_EXT_MEM_END));

  always_comb begin
    state_nxt = state;
    if (bus.rw_halt) begin
      state_nxt = st_wait;  // abandon whatever is running
    end else begin
      case (state)
        st_wait: begin
          if (hit && bus.read_q) begin
            state_nxt = st_rd_set_addr;
          end else if (hit && bus.write_q) begin
            state_nxt = st_wr_set_addr;
          end
        end
        st_rd_set_addr: state_nxt = st_rd_data_get;
        st_rd_data_get: state_nxt = st_rd_finish;
        st_rd_finish:   state_nxt = st_wait;
        st_wr_set_addr: state_nxt = st_wr_set_we;
        st_wr_set_we:   state_nxt = st_wr_finish;
        st_wr_finish:   state_nxt = st_wait;
        default:        state_nxt = st_wait;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_wait;
    end else begin
      state <= state_nxt;
    end
  end

  // payload capture
  always_ff @(posedge clk) begin
    if (state == st_wait) begin
      addr_q  <= bus.addr;   // tracks the bus until the access starts
      wdata_q <= bus.wdata;
    end
    if (state == st_rd_data_get) begin
      rd_word <= prg_rdata;  // end of the oe window
    end
  end

  assign ext_offset = addr_q - addr_t'(`MB_INT_MEM_WORDS);
  assign prg_addr   = ext_offset[`MB_SRAM_ADDR_W-1:0];
  assign prg_wdata  = wdata_q;

  // pin and done decode straight from the state
  always_comb begin
    prg_ce_n     = 1'b1;
    prg_oe_n     = 1'b1;
    prg_we_n     = 1'b1;
    prg_wdata_en = 1'b0;
    read_dn      = 1'b0;
    write_dn     = 1'b0;
    case (state)
      st_rd_set_addr, st_rd_data_get: begin
        prg_ce_n = 1'b0;
        prg_oe_n = 1'b0;  // chip drives data
      end
      st_rd_finish: begin
        prg_ce_n = 1'b0;
        read_dn  = 1'b1;
      end
      st_wr_set_addr: begin
        prg_ce_n     = 1'b0;
        prg_wdata_en = 1'b1;  // address and data settle before we
      end
      st_wr_set_we: begin
        prg_ce_n     = 1'b0;
        prg_wdata_en = 1'b1;
        prg_we_n     = 1'b0;  // single write strobe
      end
      st_wr_finish: begin
        prg_ce_n     = 1'b0;
        prg_wdata_en = 1'b1;  // hold data past the rising we edge
        write_dn     = 1'b1;
      end
      default: begin
      end
    endcase
  end

  assign rdata = read_dn ? rd_word : '0;

endmodule

`default_nettype wire

//--- baud_timer.sv
`timescale 1ns/1ps
`default_nettype none

// bit period counter for the rs232 transmitter
module baud_timer #(
  parameter int clks_per_bit = 10
) (
  input  logic clk,
  input  logic reset,
  input  logic start,  // frame begins, realign the bit grid
  output logic tick    // last clock of a bit period
);

  localparam int cnt_w = (clks_per_bit > 1) ? $clog2(clks_per_bit) : 1;
  localparam logic [cnt_w-1:0] reload = cnt_w'(clks_per_bit - 1);

  logic [cnt_w-1:0] cnt;  // counts down to zero

  always_ff @(posedge clk) begin
    if (reset || start) begin
      cnt <= reload;
    end else if (cnt == '0) begin
      cnt <= reload;  // free running, owner ignores ticks when idle
    end else begin
      cnt <= cnt - 1'b1;
    end
  end

  assign tick = (cnt == '0);

endmodule

`default_nettype wire

//--- rs232_tx_port.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_bus_cfg.svh"

module rs232_tx_port
  import mem_bus_pkg::*;
#(
  parameter int clks_per_bit = 10
) (
  input  logic     clk,
  input  logic     reset,
  mem_bus_if.slave bus,
  output data_t    rdata,
  output logic     read_dn,
  output logic     write_dn,
  output logic     tx
);

  localparam int frame_bits = 10;  // start, 8 data, stop

  logic [frame_bits-1:0] frame;    // shifts out LSB first
  logic [3:0]            bit_cnt;  // bits already sent
  logic                  busy;
  logic                  status_q;
  logic                  tick;
  logic                  hit;
  logic                  wr_accept;
  logic                  rd_accept;

  assign hit = (bus.addr == addr_t'(`MB_RS232_DATA_ADDR)) && !bus.rw_halt;

  assign wr_accept = hit && bus.write_q && !busy;     // busy holds the write off
  assign rd_accept = hit && bus.read_q && !read_dn;   // no repeat while master drops

  baud_timer #(
    .clks_per_bit(clks_per_bit)
  ) baud_timer_inst (
    .clk  (clk),
    .reset(reset),
    .start(wr_accept),  // bit grid starts with the frame
    .tick (tick)
  );

  always_ff @(posedge clk) begin
    if (reset) begin
      busy     <= 1'b0;
      bit_cnt  <= '0;
      frame    <= '1;  // line idles high
      read_dn  <= 1'b0;
      write_dn <= 1'b0;
    end else begin
      read_dn  <= rd_accept;
      write_dn <= wr_accept;
      if (wr_accept) begin
        frame   <= {1'b1, bus.wdata[7:0], 1'b0};
        bit_cnt <= '0;
        busy    <= 1'b1;
      end else if (busy && tick) begin
        frame   <= {1'b1, frame[frame_bits-1:1]};  // refill with idle level
        bit_cnt <= bit_cnt + 4'd1;
        if (bit_cnt == 4'(frame_bits - 1)) begin
          busy <= 1'b0;  // stop bit done
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rd_accept) begin
      status_q <= busy;
    end
  end

  assign tx    = frame[0];
  assign rdata = read_dn ? {{(`MB_DATA_W-1){1'b0}}, status_q} : '0;  // bit 0 busy

endmodule

`default_nettype wire

//--- mem_bus_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_bus_cfg.svh"

module mem_bus_top
  import mem_bus_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  logic       read_q,
  input  logic       write_q,
  input  logic       rw_halt,
  input  addr_t      addr,
  input  data_t      wdata,
  output data_t      rdata,
  output logic       read_dn,
  output logic       write_dn,
  output sram_addr_t prg_addr,
  output data_t      prg_wdata,
  input  data_t      prg_rdata,
  output logic       prg_wdata_en,
  output logic       prg_ce_n,
  output logic       prg_oe_n,
  output logic       prg_we_n,
  output logic       tx
);

  localparam int clks_per_bit = `MB_CLK_FREQ / `MB_BAUD;

  data_t int_rdata, ext_rdata, com_rdata;
  logic  int_read_dn, ext_read_dn, com_read_dn;
  logic  int_write_dn, ext_write_dn, com_write_dn;

  mem_bus_if bus ();

  // master side, straight from the pins
  assign bus.addr    = addr;
  assign bus.wdata   = wdata;
  assign bus.read_q  = read_q;
  assign bus.write_q = write_q;
  assign bus.rw_halt = rw_halt;

  int_startup_ram int_startup_ram_inst (
    .clk     (clk),
    .reset   (reset),
    .bus     (bus.slave),
    .rdata   (int_rdata),
    .read_dn (int_read_dn),
    .write_dn(int_write_dn)
  );

  ext_sram_ctlr ext_sram_ctlr_inst (
    .clk         (clk),
    .reset       (reset),
    .bus         (bus.slave),
    .rdata       (ext_rdata),
    .read_dn     (ext_read_dn),
    .write_dn    (ext_write_dn),
    .prg_addr    (prg_addr),
    .prg_wdata   (prg_wdata),
    .prg_rdata   (prg_rdata),
    .prg_wdata_en(prg_wdata_en),
    .prg_ce_n    (prg_ce_n),
    .prg_oe_n    (prg_oe_n),
    .prg_we_n    (prg_we_n)
  );

  rs232_tx_port #(
    .clks_per_bit(clks_per_bit)
  ) rs232_tx_port_inst (
    .clk     (clk),
    .reset   (reset),
    .bus     (bus.slave),
    .rdata   (com_rdata),
    .read_dn (com_read_dn),
    .write_dn(com_write_dn),
    .tx      (tx)
  );

  // idle slaves drive zero, so a plain OR merges the answers
  assign rdata    = int_rdata | ext_rdata | com_rdata;
  assign read_dn  = int_read_dn | ext_read_dn | com_read_dn;
  assign write_dn = int_write_dn | ext_write_dn | com_write_dn;

endmodule

`default_nettype wire

//--- sram_model.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_bus_cfg.svh"

// asynchronous program SRAM, behavioral
module sram_model
  import mem_bus_pkg::*;
(
  input  sram_addr_t addr,
  input  data_t      wdata,
  input  logic       wdata_en,  // controller owns the data pins
  input  logic       ce_n,
  input  logic       oe_n,
  input  logic       we_n,
  output data_t      rdata
);

  localparam int words = 2 ** `MB_SRAM_ADDR_W;

  data_t mem [words];

  // fill uses every address bit, stale reads stand out
  initial begin
    for (int i = 0; i < words; i++) begin
      mem[sram_addr_t'(i)] = {16'hc3a5 ^ i[15:0], i[15:0]};
    end
  end

  always @(posedge we_n) begin
    if (!ce_n && wdata_en) begin
      mem[addr] = wdata;  // data latched at the end of the strobe
    end
  end

  assign rdata = (!ce_n && !oe_n) ? mem[addr] : '0;  // chip drives only with oe

endmodule

`default_nettype wire

//--- tb_mem_bus.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_bus_cfg.svh"

module tb_mem_bus
  import mem_bus_pkg::*;
();

  localparam int    clks_per_bit = `MB_CLK_FREQ / `MB_BAUD;
  localparam int    frame_cycles = 10 * clks_per_bit;  // start, 8 data, stop
  localparam int    reset_cycles = 16;
  localparam addr_t ext_base     = 32'd256;             // first SRAM address
  localparam addr_t ext_end      = 32'd65536;
  localparam addr_t rs232_addr   = 32'hffff_fff0;
  localparam addr_t ext_addrs [3] = '{32'd256, 32'd300, 32'd65535};
  localparam logic [31:0] lfsr_seed = 32'h8fc3_5fae;
  // about 40 bus accesses at 60 cycles each, plus room for frames
  localparam int timeout_cycles = reset_cycles + 40 * 60 + 16 * frame_cycles;

  logic        clk = 1'b0;
  logic        reset, read_q, write_q, rw_halt;
  addr_t       addr;
  data_t       wdata, rdata, prg_wdata, prg_rdata;
  logic        read_dn, write_dn, tx;
  sram_addr_t  prg_addr;
  logic        prg_wdata_en, prg_ce_n, prg_oe_n, prg_we_n;
  logic [31:0] lfsr_state;
  int          cycle_cnt = 0;

  always #50 clk = ~clk;  // 100 ns period

  mem_bus_top mem_bus_top_inst (
    .clk(clk), .reset(reset), .read_q(read_q), .write_q(write_q), .rw_halt(rw_halt),
    .addr(addr), .wdata(wdata), .rdata(rdata), .read_dn(read_dn), .write_dn(write_dn),
    .prg_addr(prg_addr), .prg_wdata(prg_wdata), .prg_rdata(prg_rdata),
    .prg_wdata_en(prg_wdata_en), .prg_ce_n(prg_ce_n), .prg_oe_n(prg_oe_n),
    .prg_we_n(prg_we_n), .tx(tx)
  );

  sram_model sram_model_inst (
    .addr(prg_addr), .wdata(prg_wdata), .wdata_en(prg_wdata_en), .ce_n(prg_ce_n),
    .oe_n(prg_oe_n), .we_n(prg_we_n), .rdata(prg_rdata)
  );

  // run limit
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt > timeout_cycles) begin
      $display("timeout: tests did not finish within %0d cycles", timeout_cycles);
      $display("TEST RESULT: FAIL");
      $fatal(1, "simulation stopped by timeout");
    end
  end

  // fibonacci lfsr, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bits(input int n, output data_t w);
    w = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      w = {w[30:0], lfsr_state[0]};  // one step per bit
    end
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("MISMATCH at %0t: %s is %h, expected %h", $time, name, actual, expected);
      $display("TEST RESULT: FAIL");
      $fatal(1, "check on %s failed", name);
    end
  endtask

  // inputs change 5 ns after the edge, outputs are settled by then
  task automatic next_cycle();
    @(posedge clk);
    #5;
  endtask

  // one request held until its done pulse, latency counted in edges
  task automatic bus_access(input logic is_write, input addr_t a, input data_t wd,
                            output data_t rd, output int lat);
    logic ext;
    logic done;
    int   we_cycles;
    ext       = (a >= ext_base) && (a < ext_end);
    done      = 1'b0;
    we_cycles = 0;
    lat       = 0;
    addr      = a;
    wdata     = wd;
    write_q   = is_write;
    read_q    = !is_write;
    while (!done) begin
      next_cycle();
      lat++;
      if (ext && !prg_ce_n) begin
        check_value("prg_addr", 32'(prg_addr), a - ext_base);  // offset into SRAM
      end
      if (ext && !prg_we_n) begin
        we_cycles++;
        check_value("prg_wdata", prg_wdata, wd);
        check_value("prg_wdata_en", 32'(prg_wdata_en), 32'd1);
      end
      done = is_write ? write_dn : read_dn;
    end
    rd      = rdata;  // valid only in the done cycle
    read_q  = 1'b0;
    write_q = 1'b0;
    if (ext && is_write) begin
      check_value("prg_we_n low cycles", we_cycles, 32'd1);
    end
    next_cycle();  // idle gap before the next request
  endtask

  task automatic write_word(input addr_t a, input data_t d, input int exp_lat);
    data_t rd;
    int    lat;
    bus_access(1'b1, a, d, rd, lat);
    check_value("write_dn latency", lat, exp_lat);
  endtask

  task automatic read_expect(input addr_t a, input data_t exp_d, input int exp_lat);
    data_t rd;
    int    lat;
    bus_access(1'b0, a, '0, rd, lat);
    check_value("read_dn latency", lat, exp_lat);
    check_value("rdata", rd, exp_d);
  endtask

  // offset is the cycles already gone since the frame started
  task automatic check_tx_frame(input logic [7:0] b, input int offset);
    logic [9:0] expect_frame;
    expect_frame = {1'b1, b, 1'b0};  // stop, data msb..lsb, start
    repeat (clks_per_bit / 2 - offset) next_cycle();  // to the middle of the start bit
    for (int k = 0; k < 10; k++) begin
      if (k > 0) begin
        repeat (clks_per_bit) next_cycle();
      end
      check_value("tx", 32'(tx), 32'(expect_frame[k]));
    end
    repeat (clks_per_bit - clks_per_bit / 2) next_cycle();  // past the stop bit
  endtask

  task automatic test_int_ram();
    data_t words [8];
    for (int i = 0; i < 8; i++) begin
      take_bits(32, words[i]);
      write_word(addr_t'(i * 36 + 3), words[i], 1);  // spread up to 255
    end
    for (int i = 0; i < 8; i++) begin
      read_expect(addr_t'(i * 36 + 3), words[i], 1);
    end
  endtask

  task automatic test_ext_sram();
    data_t words [3];
    for (int i = 0; i < 3; i++) begin
      take_bits(32, words[i]);
      write_word(ext_addrs[i], words[i], 3);
    end
    for (int i = 0; i < 3; i++) begin
      read_expect(ext_addrs[i], words[i], 3);
    end
  endtask

  task automatic test_ext_latency();
    data_t d;
    take_bits(32, d);
    write_word(32'd1000, d, 3);  // one we strobe checked inside
    read_expect(32'd1000, d, 3);
  endtask

  task automatic test_abort();
    data_t d;
    take_bits(32, d);
    write_word(32'd4660, d, 3);
    addr   = 32'd4660;
    read_q = 1'b1;
    next_cycle();
    check_value("prg_ce_n", 32'(prg_ce_n), 32'd0);  // read under way
    rw_halt = 1'b1;
    repeat (6) begin
      next_cycle();
      check_value("read_dn", 32'(read_dn), 32'd0);
    end
    check_value("prg_ce_n", 32'(prg_ce_n), 32'd1);  // back in wait
    read_q  = 1'b0;
    rw_halt = 1'b0;
    next_cycle();
    read_expect(32'd4660, d, 3);
  endtask

  task automatic test_tx();
    data_t d;
    take_bits(8, d);
    write_word(rs232_addr, d, 1);
    read_expect(rs232_addr, 32'd1, 1);  // busy while shifting
    check_tx_frame(d[7:0], 3);
  endtask

  task automatic test_backpressure();
    data_t d1, d2, rd;
    int    lat;
    take_bits(8, d1);
    take_bits(8, d2);
    write_word(rs232_addr, d1, 1);
    fork
      bus_access(1'b1, rs232_addr, d2, rd, lat);  // held off by the first frame
      check_tx_frame(d1[7:0], 1);
    join
    check_value("write_dn latency", lat, frame_cycles);
    check_tx_frame(d2[7:0], 1);
    read_expect(rs232_addr, 32'd0, 1);  // idle again
  endtask

  initial begin
    reset      = 1'b1;
    read_q     = 1'b0;
    write_q    = 1'b0;
    rw_halt    = 1'b0;
    addr       = '0;
    wdata      = '0;
    lfsr_state = lfsr_seed;
    repeat (reset_cycles) next_cycle();
    reset = 1'b0;
    next_cycle();
    // everything quiet after reset
    check_value("prg_ce_n", 32'(prg_ce_n), 32'd1);
    check_value("prg_we_n", 32'(prg_we_n), 32'd1);
    check_value("prg_oe_n", 32'(prg_oe_n), 32'd1);
    check_value("prg_wdata_en", 32'(prg_wdata_en), 32'd0);
    check_value("tx", 32'(tx), 32'd1);
    check_value("read_dn", 32'(read_dn), 32'd0);
    check_value("write_dn", 32'(write_dn), 32'd0);
    test_int_ram();
    test_ext_sram();
    test_ext_latency();
    test_abort();
    test_tx();
    test_backpressure();
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

//--- compile.f
+incdir+.
mem_bus_pkg.sv
mem_bus_if.sv
int_startup_ram.sv
ext_sram_ctlr.sv
baud_timer.sv
rs232_tx_port.sv
mem_bus_top.sv
sram_model.sv
tb_mem_bus.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       := tb_mem_bus
FILELIST  := compile.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)

SOURCES := $(wildcard *.sv) $(wildcard *.svh) $(FILELIST)

.PHONY: all build run clean

all: run

build: $(SIM)

# rebuilt only when a source or the file list changes
$(SIM): $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# exit status of the simulator is the test result
run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)
